// File: src.f
+incdir+include
source/bus_pkg.sv
source/shift_add_mul.sv
source/addr_decode.sv
source/bus_execute.sv
source/bus_result.sv
source/bus_top.sv
verif/tb_bus_top.sv

// File: run.sh
#!/bin/sh
# build and run the bus slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_bus_top -f src.f --Mdir obj_dir -o tb_bus_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_bus_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASS$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

// File: include/tb_ref.svh
// bus slave reference model
`ifndef TB_REF_SVH
`define TB_REF_SVH

// mask clears the bits whose value depends on timing or unwritten ram
typedef struct packed {
    logic [7:0] rdata;
    logic [7:0] mask;
    logic       err;
} tb_exp_t;

logic [7:0]  ref_ram [0:127];
bit          ref_ram_vld [0:127];
logic [7:0]  ref_opa;
logic [7:0]  ref_opb;
logic [15:0] ref_prod;
bit          ref_pending;

function automatic logic [7:0] ref_rom(input logic [7:0] addr);
    return (addr << 2) + addr + 8'd3;
endfunction

function void ref_init();
    for (int i = 0; i < 128; i++) begin
        ref_ram_vld[i] = 1'b0;
    end
    ref_opa     = 8'h00;
    ref_opb     = 8'h00;
    ref_prod    = 16'h0000;
    ref_pending = 1'b0;
endfunction

function tb_exp_t ref_access(input bus_pkg::bus_req_t r);
    tb_exp_t e;
    int      idx;
    e   = '{rdata: 8'h00, mask: 8'hFF, err: 1'b0};
    idx = int'(r.addr) - 'h40;
    if (r.addr == 8'hFF) begin
        e.err = 1'b1;
    end else if (r.addr < 8'h40) begin
        if (r.op == bus_pkg::WRITE) begin
            e.err = 1'b1;
        end else begin
            e.rdata = ref_rom(r.addr);
        end
    end else if (r.addr < 8'hC0) begin
        if (r.op == bus_pkg::WRITE) begin
            ref_ram[idx]     = r.wdata;
            ref_ram_vld[idx] = 1'b1;
        end else if (ref_ram_vld[idx]) begin
            e.rdata = ref_ram[idx];
        end else begin
            e.mask = 8'h00;
        end
    end else if (r.op == bus_pkg::WRITE) begin
        if (r.addr == 8'hC0) begin
            ref_opa = r.wdata;
        end else if (r.addr == 8'hC1) begin
            ref_opb     = r.wdata;
            ref_prod    = ref_opa * ref_opb;
            ref_pending = 1'b1;
        end
    end else begin
        case (r.addr)
            8'hC2: begin
                e.rdata     = ref_prod[7:0];
                ref_pending = 1'b0;
            end
            8'hC3: begin
                e.rdata     = ref_prod[15:8];
                ref_pending = 1'b0;
            end
            // busy may still be set when no product read came between
            8'hC4: e.mask = ref_pending ? 8'hFE : 8'hFF;
            default: e.rdata = 8'h00;
        endcase
    end
    return e;
endfunction

`endif

// File: verif/tb_bus_top.sv
// bus slave testbench
module tb_bus_top;
    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_ref.svh"

    localparam int RAND_REQS      = 400;
    localparam int CYCLES_PER_REQ = 40;
    localparam int MAX_CYCLES     = RAND_REQS * CYCLES_PER_REQ;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic              req_ready;
    bus_pkg::bus_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    bus_pkg::bus_rsp_t rsp;

    tb_exp_t exp_q [$];
    tb_exp_t exp_cur;
    int      n_sent;
    int      n_rcvd;
    int      cycles;

    bus_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("run stopped: %s", why);
        $display("TEST FAIL");
        $fatal(1, "testbench failure");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%02h, expected 0x%02h (response %0d)",
                     name, got, exp, n_rcvd);
            abort_run("response value mismatch");
        end
    endtask

    // expected value is queued at issue, request order equals response order
    task automatic send(input bus_pkg::bus_req_t r);
        bit taken;
        exp_q.push_back(ref_access(r));
        n_sent++;
        req_valid = 1'b1;
        req       = r;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic write_bus(input logic [7:0] addr, input logic [7:0] data);
        send('{op: bus_pkg::WRITE, addr: addr, wdata: data});
    endtask

    task automatic read_bus(input logic [7:0] addr);
        send('{op: bus_pkg::READ, addr: addr, wdata: 8'h00});
    endtask

    // product reads follow the start directly and have to stall
    task automatic run_multiply(input logic [7:0] a, input logic [7:0] b);
        write_bus(bus_pkg::IO_OPA, a);
        write_bus(bus_pkg::IO_OPB, b);
        read_bus(bus_pkg::IO_PLO);
        read_bus(bus_pkg::IO_PHI);
        read_bus(bus_pkg::IO_STAT);
    endtask

    // random back-pressure, about 70 percent ready
    always @(posedge clk) begin
        #1;
        rsp_ready = $urandom_range(0, 9) < 7;
    end

    always @(negedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a response arrived with no request outstanding");
            end else begin
                exp_cur = exp_q.pop_front();
                check_value("rsp.err", {7'd0, rsp.err}, {7'd0, exp_cur.err});
                check_value("rsp.rdata", rsp.rdata & exp_cur.mask,
                            exp_cur.rdata & exp_cur.mask);
                n_rcvd++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            abort_run($sformatf("no finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        int         sel;
        logic [7:0] addr;
        void'($urandom(8));
        ref_init();
        n_sent    = 0;
        n_rcvd    = 0;
        cycles    = 0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        // rom reads, then rejected rom writes
        for (int a = 0; a < 64; a++) begin
            read_bus(8'(a));
        end
        for (int a = 0; a < 64; a += 9) begin
            write_bus(8'(a), 8'hA5);
            read_bus(8'(a));
        end

        // fill and read back the whole ram
        for (int a = 'h40; a < 'hC0; a++) begin
            write_bus(8'(a), 8'(a * 7 + 'h11));
        end
        for (int a = 'h40; a < 'hC0; a++) begin
            read_bus(8'(a));
        end

        run_multiply(8'd3, 8'd5);
        run_multiply(8'hFF, 8'hFF);
        run_multiply(8'h00, 8'hC8);
        run_multiply(8'h80, 8'h02);
        // restart while busy stalls until the first multiply ends
        write_bus(bus_pkg::IO_OPB, 8'h11);
        write_bus(bus_pkg::IO_OPB, 8'h0D);
        read_bus(bus_pkg::IO_PHI);
        read_bus(bus_pkg::IO_PLO);
        read_bus(bus_pkg::IO_STAT);
        write_bus(8'hC7, 8'h55);
        read_bus(8'hC7);
        read_bus(8'hFE);

        // error address leaves ram untouched
        write_bus(8'h80, 8'h3C);
        write_bus(bus_pkg::ERR_ADDR, 8'hC3);
        read_bus(bus_pkg::ERR_ADDR);
        read_bus(8'h80);
        read_bus(8'h40);
        read_bus(8'hBF);

        for (int i = 0; i < RAND_REQS; i++) begin
            sel = $urandom_range(0, 3);
            if (sel == 3) begin
                addr = 8'(bus_pkg::IO_OPA + $urandom_range(0, 5));
            end else begin
                addr = 8'($urandom_range(0, 255));
            end
            if ($urandom_range(0, 1) == 1) begin
                write_bus(addr, 8'($urandom_range(0, 255)));
            end else begin
                read_bus(addr);
            end
            if ($urandom_range(0, 4) == 0) begin
                @(posedge clk);
                #1;
            end
        end

        while (n_rcvd != n_sent) begin
            @(posedge clk);
        end
        // extra responses would show up here
        repeat (20) @(posedge clk);
        if (n_rcvd == n_sent && exp_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("response count differs from request count");
        end
    end

endmodule

// File: source/bus_top.sv
// memory-mapped slave top
module bus_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  bus_pkg::bus_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output bus_pkg::bus_rsp_t rsp
);

    logic              dec_valid;
    logic              dec_ready;
    bus_pkg::dec_req_t dec;
    logic              exe_valid;
    logic              exe_ready;
    bus_pkg::bus_rsp_t exe_rsp;

    addr_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec)
    );

    bus_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec       (dec),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe_rsp   (exe_rsp)
    );

    bus_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe_rsp   (exe_rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// File: source/bus_result.sv
// response register stage
module bus_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exe_valid,
    output logic              exe_ready,
    input  bus_pkg::bus_rsp_t exe_rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output bus_pkg::bus_rsp_t rsp
);

    logic full;
    logic load;

    // take a new response when empty or draining
    assign exe_ready = !full || rsp_ready;
    assign load      = exe_valid && exe_ready;
    assign rsp_valid = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (rsp_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp <= exe_rsp;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// File: source/bus_execute.sv
// execute stage
module bus_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_valid,
    output logic              dec_ready,
    input  bus_pkg::dec_req_t dec,
    output logic              exe_valid,
    input  logic              exe_ready,
    output bus_pkg::bus_rsp_t exe_rsp
);

    logic [7:0]  ram [0:127];
    logic [6:0]  ram_idx;
    logic [7:0]  opa_q;
    logic [7:0]  opb_q;
    logic [15:0] prod_q;
    logic [15:0] mul_product;
    logic        busy;
    logic        mul_start;
    logic        mul_done;
    logic        is_wr;
    logic        is_rd;
    logic        opb_wr;
    logic        prod_rd;
    logic        stall;
    logic        accept;

    assign is_wr   = dec.req.op == bus_pkg::WRITE;
    assign is_rd   = dec.req.op == bus_pkg::READ;
    assign opb_wr  = is_wr && (dec.req.addr == bus_pkg::IO_OPB);
    assign prod_rd = is_rd && ((dec.req.addr == bus_pkg::IO_PLO) ||
                               (dec.req.addr == bus_pkg::IO_PHI));

    // hold product reads and restarts until the multiply is done
    assign stall     = busy && (opb_wr || prod_rd);
    assign exe_valid = dec_valid && !stall;
    assign dec_ready = exe_ready && !stall;
    assign accept    = dec_valid && dec_ready;

    assign ram_idx = 7'(dec.req.addr - bus_pkg::RAM_BASE);

    always_ff @(posedge clk) begin
        if (accept && is_wr && (dec.region == bus_pkg::REG_RAM)) begin
            ram[ram_idx] <= dec.req.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_q     <= 8'h00;
            opb_q     <= 8'h00;
            prod_q    <= 16'h0000;
            busy      <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            mul_start <= accept && opb_wr;
            if (accept && is_wr && (dec.req.addr == bus_pkg::IO_OPA)) begin
                opa_q <= dec.req.wdata;
            end
            if (accept && opb_wr) begin
                opb_q <= dec.req.wdata;
                busy  <= 1'b1;
            end else if (mul_done) begin
                busy <= 1'b0;
            end
            if (mul_done) begin
                prod_q <= mul_product;
            end
        end
    end

    // response data, writes answer with zero
    always_comb begin
        exe_rsp = '0;
        case (dec.region)
            bus_pkg::REG_ROM: begin
                if (is_wr) begin
                    exe_rsp.err = 1'b1;
                end else begin
                    exe_rsp.rdata = bus_pkg::rom_word(dec.req.addr);
                end
            end
            bus_pkg::REG_RAM: begin
                if (is_rd) begin
                    exe_rsp.rdata = ram[ram_idx];
                end
            end
            bus_pkg::REG_IO: begin
                if (is_rd) begin
                    case (dec.req.addr)
                        bus_pkg::IO_PLO:  exe_rsp.rdata = prod_q[7:0];
                        bus_pkg::IO_PHI:  exe_rsp.rdata = prod_q[15:8];
                        bus_pkg::IO_STAT: exe_rsp.rdata = {7'd0, busy};
                        default:          exe_rsp.rdata = 8'h00;
                    endcase
                end
            end
            default: begin
                exe_rsp.err = 1'b1;
            end
        endcase
    end

    shift_add_mul u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .multiplicand (opa_q),
        .multiplier   (opb_q),
        .product      (mul_product),
        .done         (mul_done)
    );

    // done only ever closes a multiply this stage started
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> busy);

endmodule

// File: source/addr_decode.sv
// address decode stage
module addr_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    output logic              req_ready,
    input  bus_pkg::bus_req_t req,
    output logic              dec_valid,
    input  logic              dec_ready,
    output bus_pkg::dec_req_t dec
);

    logic             rom_sel;
    logic             ram_sel;
    logic             io_sel;
    logic             err_sel;
    bus_pkg::region_e region;
    logic             full;
    logic             accept;

    // parallel range checks, one of them is always set
    always_comb begin
        rom_sel = req.addr < bus_pkg::RAM_BASE;
        ram_sel = (req.addr >= bus_pkg::RAM_BASE) && (req.addr < bus_pkg::IO_BASE);
        io_sel  = (req.addr >= bus_pkg::IO_BASE) && (req.addr < bus_pkg::ERR_ADDR);
        err_sel = req.addr == bus_pkg::ERR_ADDR;
        case (1'b1)
            rom_sel: region = bus_pkg::REG_ROM;
            ram_sel: region = bus_pkg::REG_RAM;
            io_sel:  region = bus_pkg::REG_IO;
            err_sel: region = bus_pkg::REG_ERR;
            default: region = bus_pkg::REG_ERR;
        endcase
    end

    // one-entry stage, refills while draining
    assign req_ready = !full || dec_ready;
    assign accept    = req_valid && req_ready;
    assign dec_valid = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (dec_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.req    <= req;
            dec.region <= region;
        end
    end

    // downstream sees a stable request until it takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

// File: source/shift_add_mul.sv
// sequential shift-add multiplier
module shift_add_mul (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [7:0]  multiplicand,
    input  logic [7:0]  multiplier,
    output logic [15:0] product,
    output logic        done
);

    bus_pkg::mul_state_e state;
    bus_pkg::mul_state_e next_state;
    logic [15:0]         mcand_q;
    logic [7:0]          mplier_q;
    logic [15:0]         acc_q;
    logic [3:0]          bit_cnt;

    always_comb begin
        case (state)
            bus_pkg::IDLE:   next_state = start ? bus_pkg::CALC : bus_pkg::IDLE;
            bus_pkg::CALC:   next_state = (bit_cnt == 4'd7) ? bus_pkg::FINISH : bus_pkg::CALC;
            bus_pkg::FINISH: next_state = bus_pkg::IDLE;
            default:         next_state = bus_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= bus_pkg::IDLE;
            bit_cnt <= 4'd0;
            done    <= 1'b0;
        end else begin
            state <= next_state;
            done  <= state == bus_pkg::FINISH;
            if (state == bus_pkg::IDLE) begin
                bit_cnt <= 4'd0;
            end else if (state == bus_pkg::CALC) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            bus_pkg::IDLE: begin
                if (start) begin
                    mcand_q  <= {8'h00, multiplicand};
                    mplier_q <= multiplier;
                    acc_q    <= 16'h0000;
                end
            end
            bus_pkg::CALC: begin
                if (mplier_q[0]) begin
                    acc_q <= acc_q + mcand_q;
                end
                mplier_q <= mplier_q >> 1;
                mcand_q  <= mcand_q << 1;
            end
            bus_pkg::FINISH: begin
                product <= acc_q;
            end
            default: begin
                acc_q <= acc_q;
            end
        endcase
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == bus_pkg::IDLE);

endmodule

// File: source/bus_pkg.sv
// bus slave shared definitions
package bus_pkg;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } bus_op_e;

    typedef enum logic [1:0] {
        REG_ROM = 2'd0,
        REG_RAM = 2'd1,
        REG_IO  = 2'd2,
        REG_ERR = 2'd3
    } region_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        CALC   = 2'd1,
        FINISH = 2'd2
    } mul_state_e;

    typedef struct packed {
        bus_op_e    op;
        logic [7:0] addr;
        logic [7:0] wdata;
    } bus_req_t;

    typedef struct packed {
        bus_req_t req;
        region_e  region;
    } dec_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       err;
    } bus_rsp_t;

    // address map
    localparam logic [7:0] RAM_BASE = 8'h40;
    localparam logic [7:0] IO_BASE  = 8'hC0;
    localparam logic [7:0] ERR_ADDR = 8'hFF;

    // multiplier registers in the io window
    localparam logic [7:0] IO_OPA  = 8'hC0;
    localparam logic [7:0] IO_OPB  = 8'hC1;
    localparam logic [7:0] IO_PLO  = 8'hC2;
    localparam logic [7:0] IO_PHI  = 8'hC3;
    localparam logic [7:0] IO_STAT = 8'hC4;

    // fixed rom contents, addr * 5 + 3
    function automatic logic [7:0] rom_word(input logic [7:0] addr);
        return addr * 8'd5 + 8'd3;
    endfunction

endpackage
